//--- global_pkg.sv
// package: sizes, register word types, register address map, control bits, read defaults
package global_pkg;

   ////////////////////////////////////////////////////////////
   // sizes
   ////////////////////////////////////////////////////////////
   localparam int KERNEL_NUM   = 8;
   localparam int DATA_W       = 32;
   localparam int ADDR_W       = 32;
   localparam int KERNEL_IDX_W = $clog2(KERNEL_NUM);

   typedef logic [KERNEL_NUM-1:0] kernel_vec_t;
   typedef logic [DATA_W-1:0]     word_t;
   typedef logic [ADDR_W-1:0]     addr_t;

   ////////////////////////////////////////////////////////////
   // register map
   ////////////////////////////////////////////////////////////
   // kernel counts sit at KERNEL_CNT_BASE + 4*k, up to 0x64
   typedef enum addr_t {
      ACTION_TYPE     = 32'h10,
      ACTION_VERSION  = 32'h14,
      INTR_CONTROL    = 32'h30,
      INTR_MASK       = 32'h34,
      GLOBAL_CONTROL  = 32'h38,
      INIT_ADDR_HI    = 32'h3C,
      INIT_ADDR_LO    = 32'h40,
      GLOBAL_DONE     = 32'h44,
      KERNEL_CNT_BASE = 32'h48,
      CMPL_ADDR_HI    = 32'h68,
      CMPL_ADDR_LO    = 32'h6C,
      CMPL_SIZE       = 32'h70
   } reg_addr_e;

   // global control word bits
   localparam int CTRL_START_BIT    = 0;
   localparam int CTRL_RUN_MODE_BIT = 8;

   localparam word_t      RD_UNMAPPED = 32'h5A5AA5A5;
   localparam logic [1:0] RESP_OKAY   = 2'b00;

endpackage

//--- axil_reg_port.sv
// AXI-Lite slave handshake engine: write strobes and read requests toward the register file
`timescale 1ns/1ns

module axil_reg_port (
   input  logic               clk,
   input  logic               rst_n,
   // write address / data / response
   input  logic               awvalid,
   input  global_pkg::addr_t  awaddr,
   output logic               awready,
   input  logic               wvalid,
   input  global_pkg::word_t  wdata,
   output logic               wready,
   output logic               bvalid,
   output logic [1:0]         bresp,
   input  logic               bready,
   // read address / data
   input  logic               arvalid,
   input  global_pkg::addr_t  araddr,
   output logic               arready,
   output logic               rvalid,
   output global_pkg::word_t  rdata,
   output logic [1:0]         rresp,
   input  logic               rready,
   // register file side
   output logic               wr_en,
   output global_pkg::addr_t  wr_addr,
   output global_pkg::word_t  wr_data,
   output logic               rd_en,
   output global_pkg::addr_t  rd_addr,
   input  global_pkg::word_t  rd_value
);
   import global_pkg::*;

   ////////////////////////////////////////////////////////////
   // write channel
   ////////////////////////////////////////////////////////////
   assign wr_en   = wvalid & wready;
   assign wr_data = wdata;

   // address held until the data beat arrives
   always_ff @(posedge clk) begin
      if (awvalid & awready)
         wr_addr <= awaddr;
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         awready <= 1'b0;
         wready  <= 1'b0;
         bvalid  <= 1'b0;
      end else begin
         if (awvalid)
            awready <= 1'b1;
         else if (wr_en)
            awready <= 1'b0;

         if (awvalid & awready)
            wready <= 1'b1;
         else if (wvalid)
            wready <= 1'b0;

         // response holds until the master takes it
         if (wr_en)
            bvalid <= 1'b1;
         else if (bready)
            bvalid <= 1'b0;
      end
   end

   ////////////////////////////////////////////////////////////
   // read channel
   ////////////////////////////////////////////////////////////
   assign rd_en   = arvalid & arready;
   assign rd_addr = araddr;

   always_ff @(posedge clk) begin
      if (rd_en)
         rdata <= rd_value;
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         arready <= 1'b1;
         rvalid  <= 1'b0;
      end else begin
         // closed from the address beat until the data beat is taken
         if (arvalid)
            arready <= 1'b0;
         else if (rvalid & rready)
            arready <= 1'b1;

         if (rd_en)
            rvalid <= 1'b1;
         else if (rready)
            rvalid <= 1'b0;
      end
   end

   assign bresp = RESP_OKAY;
   assign rresp = RESP_OKAY;

endmodule

//--- global_regs.sv
// control register file: write decode, interrupt clear pulse, read data select
`timescale 1ns/1ns

module global_regs (
   input  logic                      clk,
   input  logic                      rst_n,
   input  logic                      wr_en,
   input  global_pkg::addr_t         wr_addr,
   input  global_pkg::word_t         wr_data,
   input  global_pkg::addr_t         rd_addr,
   input  global_pkg::word_t         action_type,
   input  global_pkg::word_t         action_version,
   input  global_pkg::kernel_vec_t   mask,
   input  logic                      done_flag,
   input  global_pkg::word_t [global_pkg::KERNEL_NUM-1:0] kernel_counts,
   output global_pkg::word_t         rd_value,
   output global_pkg::kernel_vec_t   intr_clear,
   output logic                      manager_start,
   output logic                      run_mode,
   output logic [63:0]               init_addr,
   output logic [63:0]               completion_addr,
   output global_pkg::word_t         completion_size
);
   import global_pkg::*;

   word_t global_ctrl;
   word_t init_hi;
   word_t init_lo;
   word_t cmpl_hi;
   word_t cmpl_lo;
   word_t cmpl_size;
   word_t intr_ctrl;
   addr_t cnt_off;
   logic  cnt_hit;

   ////////////////////////////////////////////////////////////
   // write decode
   ////////////////////////////////////////////////////////////
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         global_ctrl <= '0;
         init_hi     <= '0;
         init_lo     <= '0;
         cmpl_hi     <= '0;
         cmpl_lo     <= '0;
         cmpl_size   <= '0;
         intr_ctrl   <= '0;
      end else if (wr_en) begin
         case (wr_addr)
            GLOBAL_CONTROL: global_ctrl <= wr_data;
            INIT_ADDR_HI:   init_hi     <= wr_data;
            INIT_ADDR_LO:   init_lo     <= wr_data;
            CMPL_ADDR_HI:   cmpl_hi     <= wr_data;
            CMPL_ADDR_LO:   cmpl_lo     <= wr_data;
            CMPL_SIZE:      cmpl_size   <= wr_data;
            INTR_CONTROL:   intr_ctrl   <= wr_data;
            default: ;
         endcase
      end
   end

   // write-one-to-clear toward the mask, same edge as the store
   assign intr_clear = (wr_en && wr_addr == INTR_CONTROL) ? wr_data[KERNEL_NUM-1:0] : '0;

   assign manager_start   = global_ctrl[CTRL_START_BIT];
   assign run_mode        = global_ctrl[CTRL_RUN_MODE_BIT];
   assign init_addr       = {init_hi, init_lo};
   assign completion_addr = {cmpl_hi, cmpl_lo};
   assign completion_size = cmpl_size;

   ////////////////////////////////////////////////////////////
   // read select
   ////////////////////////////////////////////////////////////
   assign cnt_off = rd_addr - KERNEL_CNT_BASE;
   assign cnt_hit = (cnt_off < addr_t'(KERNEL_NUM * 4)) && (cnt_off[1:0] == 2'b00);

   always_comb begin
      case (rd_addr)
         ACTION_TYPE:    rd_value = action_type;
         ACTION_VERSION: rd_value = action_version;
         INTR_CONTROL:   rd_value = intr_ctrl;
         INTR_MASK:      rd_value = {{(DATA_W-KERNEL_NUM){1'b0}}, mask};
         GLOBAL_CONTROL: rd_value = global_ctrl;
         INIT_ADDR_HI:   rd_value = init_hi;
         INIT_ADDR_LO:   rd_value = init_lo;
         GLOBAL_DONE:    rd_value = {{(DATA_W-1){1'b0}}, done_flag};
         CMPL_ADDR_HI:   rd_value = cmpl_hi;
         CMPL_ADDR_LO:   rd_value = cmpl_lo;
         CMPL_SIZE:      rd_value = cmpl_size;
         // counter window, anything else is unmapped
         default:        rd_value = cnt_hit ? kernel_counts[cnt_off[2 +: KERNEL_IDX_W]]
                                            : RD_UNMAPPED;
      endcase
   end

endmodule

//--- kernel_dispatch.sv
// kernel dispatcher: busy tracking, idle-kernel priority pick, completion edge detect
`timescale 1ns/1ns

module kernel_dispatch (
   input  logic                     clk,
   input  logic                     rst_n,
   input  logic                     job_start,
   input  global_pkg::kernel_vec_t  kernel_complete,
   output global_pkg::kernel_vec_t  kernel_start,
   output global_pkg::kernel_vec_t  complete_rise,
   output logic                     new_job,
   output logic                     job_done
);
   import global_pkg::*;

   kernel_vec_t busy;
   kernel_vec_t complete_prev;
   kernel_vec_t pick;

   // prev starts at ones so a level high out of reset is no edge
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n)
         complete_prev <= '1;
      else
         complete_prev <= kernel_complete;
   end

   assign complete_rise = kernel_complete & ~complete_prev;

   ////////////////////////////////////////////////////////////
   // priority pick, highest idle index wins
   ////////////////////////////////////////////////////////////
   always_comb begin
      pick = '0;
      for (int k = 0; k < KERNEL_NUM; k++) begin
         if (!busy[k]) begin
            pick    = '0;
            pick[k] = 1'b1;
         end
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         kernel_start <= '0;
         busy         <= '0;
      end else begin
         kernel_start <= job_start ? pick : '0;
         // start wins over a completion in the same cycle
         busy         <= (busy & ~complete_rise) | kernel_start;
      end
   end

   assign new_job  = ~&busy;
   assign job_done = ~|busy;

endmodule

//--- completion_monitor.sv
// completion monitor: per-kernel completion counters and sticky all-idle flag
`timescale 1ns/1ns

module completion_monitor (
   input  logic                     clk,
   input  logic                     rst_n,
   input  logic                     manager_start,
   input  global_pkg::kernel_vec_t  complete_rise,
   input  logic                     job_done,
   output global_pkg::word_t [global_pkg::KERNEL_NUM-1:0] kernel_counts,
   output logic                     real_done
);
   import global_pkg::*;

   logic job_done_d;

   // one counter per kernel
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         kernel_counts <= '0;
      end else if (manager_start) begin
         kernel_counts <= '0;
      end else begin
         for (int k = 0; k < KERNEL_NUM; k++) begin
            if (complete_rise[k])
               kernel_counts[k] <= kernel_counts[k] + 1'b1;
         end
      end
   end

   ////////////////////////////////////////////////////////////
   // done flag on rising job_done
   ////////////////////////////////////////////////////////////
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         job_done_d <= 1'b0;
         real_done  <= 1'b0;
      end else begin
         job_done_d <= job_done;
         if (manager_start)
            real_done <= 1'b0;
         else if (job_done && !job_done_d)
            real_done <= 1'b1;
      end
   end

endmodule

//--- irq_ctrl.sv
// interrupt controller: pending completions, mask load and clear, request with ack
`timescale 1ns/1ns

module irq_ctrl (
   input  logic                     clk,
   input  logic                     rst_n,
   input  global_pkg::kernel_vec_t  complete_rise,
   input  global_pkg::kernel_vec_t  intr_clear,
   input  logic                     interrupt_ack,
   output global_pkg::kernel_vec_t  mask,
   output logic                     interrupt
);
   import global_pkg::*;

   typedef enum logic {
      IRQ_ARMED,
      IRQ_WAIT_CLEAR
   } irq_state_e;

   irq_state_e  state;
   kernel_vec_t pending;

   ////////////////////////////////////////////////////////////
   // pending set and mask
   ////////////////////////////////////////////////////////////
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         pending <= '0;
         mask    <= '0;
      end else begin
         // bits already in the mask are not collected again
         pending <= (pending | complete_rise) & ~mask;
         if (mask == '0 && intr_clear == '0)
            mask <= pending;
         else if (intr_clear != '0)
            mask <= mask & ~intr_clear;
      end
   end

   // after an ack, stay quiet until software has emptied the mask
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state     <= IRQ_ARMED;
         interrupt <= 1'b0;
      end else if (interrupt_ack) begin
         state     <= IRQ_WAIT_CLEAR;
         interrupt <= 1'b0;
      end else if (state == IRQ_WAIT_CLEAR) begin
         if (mask == '0)
            state <= IRQ_ARMED;
      end else begin
         interrupt <= |mask;
      end
   end

endmodule

//--- global_slave_top.sv
// top level: bus port, register file, dispatcher, completion monitor, interrupt controller
`timescale 1ns/1ns

module global_slave_top (
   input  logic                     clk,
   input  logic                     rst_n,
   input  logic                     awvalid,
   input  global_pkg::addr_t        awaddr,
   output logic                     awready,
   input  logic                     wvalid,
   input  global_pkg::word_t        wdata,
   output logic                     wready,
   output logic                     bvalid,
   output logic [1:0]               bresp,
   input  logic                     bready,
   input  logic                     arvalid,
   input  global_pkg::addr_t        araddr,
   output logic                     arready,
   output logic                     rvalid,
   output global_pkg::word_t        rdata,
   output logic [1:0]               rresp,
   input  logic                     rready,
   // kernel side and local control
   input  logic                     job_start,
   input  global_pkg::kernel_vec_t  kernel_complete,
   input  global_pkg::word_t        action_type,
   input  global_pkg::word_t        action_version,
   input  logic                     i_interrupt_ack,
   output global_pkg::kernel_vec_t  kernel_start,
   output logic                     manager_start,
   output logic                     run_mode,
   output logic [63:0]              init_addr,
   output logic [63:0]              completion_addr,
   output global_pkg::word_t        completion_size,
   output logic                     new_job,
   output logic                     job_done,
   output logic                     real_done,
   output logic                     o_interrupt
);
   import global_pkg::*;

   logic        wr_en;
   addr_t       wr_addr;
   word_t       wr_data;
   addr_t       rd_addr;
   word_t       rd_value;
   kernel_vec_t intr_clear;
   kernel_vec_t mask;
   kernel_vec_t complete_rise;
   word_t [KERNEL_NUM-1:0] kernel_counts;

   axil_reg_port u_port (
      .clk, .rst_n, .awvalid, .awaddr, .awready, .wvalid, .wdata, .wready,
      .bvalid, .bresp, .bready, .arvalid, .araddr, .arready, .rvalid, .rdata,
      .rresp, .rready, .wr_en, .wr_addr, .wr_data, .rd_en(), .rd_addr, .rd_value
   );

   global_regs u_regs (
      .clk, .rst_n, .wr_en, .wr_addr, .wr_data, .rd_addr, .action_type,
      .action_version, .mask, .done_flag(real_done), .kernel_counts, .rd_value,
      .intr_clear, .manager_start, .run_mode, .init_addr, .completion_addr,
      .completion_size
   );

   kernel_dispatch u_dispatch (
      .clk, .rst_n, .job_start, .kernel_complete, .kernel_start, .complete_rise,
      .new_job, .job_done
   );

   completion_monitor u_monitor (
      .clk, .rst_n, .manager_start, .complete_rise, .job_done, .kernel_counts,
      .real_done
   );

   irq_ctrl u_irq (
      .clk, .rst_n, .complete_rise, .intr_clear, .interrupt_ack(i_interrupt_ack),
      .mask, .interrupt(o_interrupt)
   );

endmodule

//--- tb_global_slave.sv
// testbench: bus tasks, check task, directed tests for the global register block, watchdog
`timescale 1ns/1ns

module tb_global_slave;
   import global_pkg::*;

   localparam int    CLK_HALF        = 20;
   localparam int    RESET_CYCLES    = 10;
   localparam int    WATCHDOG_CYCLES = 5000;
   localparam int    SEED            = 94;
   localparam word_t TYPE_ID         = 32'h0000_10C4;
   localparam word_t VERSION_ID      = 32'h0003_0201;

   logic        clk = 1'b0;
   logic        rst_n;
   logic        awvalid, awready, wvalid, wready, bvalid, bready;
   logic        arvalid, arready, rvalid, rready;
   logic [1:0]  bresp, rresp;
   addr_t       awaddr, araddr;
   word_t       wdata, rdata;
   logic        job_start, i_interrupt_ack;
   kernel_vec_t kernel_complete, kernel_start;
   word_t       action_type, action_version, completion_size;
   logic        manager_start, run_mode, new_job, job_done, real_done, o_interrupt;
   logic [63:0] init_addr, completion_addr;
   int unsigned exp_cnt [KERNEL_NUM];

   global_slave_top dut0 (.*);

   always #CLK_HALF clk = ~clk;

   ////////////////////////////////////////////////////////////
   // check and bus tasks
   ////////////////////////////////////////////////////////////
   task automatic check_value(input string name, input logic [63:0] got,
                              input logic [63:0] exp);
      if (got !== exp) begin
         $display("** Error %s: got 0x%h, expected 0x%h", name, got, exp);
         $display("Some tests failed");
         $fatal(1, "mismatch on %s", name);
      end
   endtask

   // address and data offered together, response taken at once
   task automatic axi_write(input addr_t addr, input word_t data);
      @(negedge clk);
      awaddr  = addr;
      awvalid = 1'b1;
      wdata   = data;
      wvalid  = 1'b1;
      bready  = 1'b1;
      do @(negedge clk); while (!awready);
      @(negedge clk);
      awvalid = 1'b0;
      while (!wready) @(negedge clk);
      @(negedge clk);
      wvalid = 1'b0;
      while (!bvalid) @(negedge clk);
      // every response is OKAY
      check_value("bresp", bresp, 2'b00);
      @(negedge clk);
      bready = 1'b0;
   endtask

   task automatic axi_read(input addr_t addr, output word_t data);
      @(negedge clk);
      while (!arready) @(negedge clk);
      araddr  = addr;
      arvalid = 1'b1;
      rready  = 1'b1;
      @(negedge clk);
      arvalid = 1'b0;
      while (!rvalid) @(negedge clk);
      check_value("rresp", rresp, 2'b00);
      data = rdata;
      @(negedge clk);
      rready = 1'b0;
   endtask

   task automatic read_expect(input addr_t addr, input word_t exp, input string name);
      word_t got;
      axi_read(addr, got);
      check_value(name, got, exp);
   endtask

   // start seen one cycle after the pulse
   task automatic pulse_job(output kernel_vec_t started);
      @(negedge clk);
      job_start = 1'b1;
      @(negedge clk);
      job_start = 1'b0;
      started = kernel_start;
   endtask

   task automatic pulse_complete(input kernel_vec_t vec);
      for (int k = 0; k < KERNEL_NUM; k++)
         if (vec[k])
            exp_cnt[k]++;
      @(negedge clk);
      kernel_complete = vec;
      repeat (2) @(negedge clk);
      kernel_complete = '0;
      repeat (3) @(negedge clk);
   endtask

   task automatic wait_interrupt(input logic level);
      int n;
      n = 0;
      while (o_interrupt !== level) begin
         @(negedge clk);
         n++;
         if (n > 8) begin
            $display("o_interrupt did not reach %0b within 8 cycles", level);
            $display("Some tests failed");
            $fatal(1, "interrupt wait timed out");
         end
      end
   endtask

   ////////////////////////////////////////////////////////////
   // directed tests
   ////////////////////////////////////////////////////////////
   task automatic test_reset_identity();
      check_value("bvalid", bvalid, 0);
      check_value("rvalid", rvalid, 0);
      check_value("o_interrupt", o_interrupt, 0);
      check_value("kernel_start", kernel_start, 0);
      check_value("manager_start", manager_start, 0);
      check_value("real_done", real_done, 1);
      read_expect(ACTION_TYPE, TYPE_ID, "ACTION_TYPE");
      read_expect(ACTION_VERSION, VERSION_ID, "ACTION_VERSION");
      read_expect(32'h0000_0100, 32'h5A5A_A5A5, "unmapped");
      read_expect(GLOBAL_DONE, 32'h1, "GLOBAL_DONE");
   endtask

   task automatic test_control_regs();
      word_t ihi, ilo, chi, clo, size;
      ihi  = $urandom;
      ilo  = $urandom;
      chi  = $urandom;
      clo  = $urandom;
      size = $urandom;
      axi_write(INIT_ADDR_HI, ihi);
      axi_write(INIT_ADDR_LO, ilo);
      axi_write(CMPL_ADDR_HI, chi);
      axi_write(CMPL_ADDR_LO, clo);
      axi_write(CMPL_SIZE, size);
      read_expect(INIT_ADDR_HI, ihi, "INIT_ADDR_HI");
      read_expect(INIT_ADDR_LO, ilo, "INIT_ADDR_LO");
      read_expect(CMPL_ADDR_HI, chi, "CMPL_ADDR_HI");
      read_expect(CMPL_ADDR_LO, clo, "CMPL_ADDR_LO");
      read_expect(CMPL_SIZE, size, "CMPL_SIZE");
      check_value("init_addr", init_addr, {ihi, ilo});
      check_value("completion_addr", completion_addr, {chi, clo});
      check_value("completion_size", completion_size, size);
      axi_write(GLOBAL_CONTROL, 32'h100);
      check_value("run_mode", run_mode, 1);
      check_value("manager_start", manager_start, 0);
      axi_write(GLOBAL_CONTROL, 32'h101);
      check_value("manager_start", manager_start, 1);
      read_expect(GLOBAL_CONTROL, 32'h101, "GLOBAL_CONTROL");
      axi_write(GLOBAL_CONTROL, 32'h0);
      check_value("run_mode", run_mode, 0);
      check_value("manager_start", manager_start, 0);
   endtask

   // kernels taken from the top index down
   task automatic test_dispatch();
      kernel_vec_t got;
      for (int i = 0; i < KERNEL_NUM; i++) begin
         pulse_job(got);
         check_value("kernel_start", got, kernel_vec_t'(1) << (KERNEL_NUM - 1 - i));
         repeat (3) @(negedge clk);
         check_value("kernel_start", kernel_start, 0);
         check_value("new_job", new_job, i < KERNEL_NUM - 1);
      end
      pulse_job(got);
      check_value("kernel_start", got, 0);
      check_value("job_done", job_done, 0);
   endtask

   task automatic test_completion();
      pulse_complete(8'hFF);
      check_value("job_done", job_done, 1);
      check_value("real_done", real_done, 1);
      pulse_complete(8'h84);
      pulse_complete(8'h04);
      for (int k = 0; k < KERNEL_NUM; k++)
         read_expect(addr_t'(KERNEL_CNT_BASE) + addr_t'(4 * k), exp_cnt[k],
                     $sformatf("KERNEL_CNT%0d", k));
      read_expect(GLOBAL_DONE, 32'h1, "GLOBAL_DONE");
      axi_write(GLOBAL_CONTROL, 32'h1);
      axi_write(GLOBAL_CONTROL, 32'h0);
      for (int k = 0; k < KERNEL_NUM; k++) begin
         exp_cnt[k] = 0;
         read_expect(addr_t'(KERNEL_CNT_BASE) + addr_t'(4 * k), 32'h0,
                     $sformatf("KERNEL_CNT%0d", k));
      end
      read_expect(GLOBAL_DONE, 32'h0, "GLOBAL_DONE");
      // empty the mask left by these completions
      axi_write(INTR_CONTROL, 32'hFF);
      repeat (2) @(negedge clk);
      check_value("o_interrupt", o_interrupt, 0);
      read_expect(INTR_MASK, 32'h0, "INTR_MASK");
   endtask

   task automatic test_interrupt();
      pulse_complete(8'h08);
      wait_interrupt(1'b1);
      read_expect(INTR_MASK, 32'h08, "INTR_MASK");
      @(negedge clk);
      i_interrupt_ack = 1'b1;
      @(negedge clk);
      i_interrupt_ack = 1'b0;
      check_value("o_interrupt", o_interrupt, 0);
      // mask still set, request must stay down
      repeat (3) @(negedge clk);
      check_value("o_interrupt", o_interrupt, 0);
      axi_write(INTR_CONTROL, 32'h08);
      read_expect(INTR_CONTROL, 32'h08, "INTR_CONTROL");
      read_expect(INTR_MASK, 32'h0, "INTR_MASK");
      pulse_complete(8'h20);
      wait_interrupt(1'b1);
      read_expect(INTR_MASK, 32'h20, "INTR_MASK");
   endtask

   ////////////////////////////////////////////////////////////
   // main sequence and watchdog
   ////////////////////////////////////////////////////////////
   initial begin
      void'($urandom(SEED));
      rst_n           = 1'b0;
      awvalid         = 1'b0;
      awaddr          = '0;
      wvalid          = 1'b0;
      wdata           = '0;
      bready          = 1'b0;
      arvalid         = 1'b0;
      araddr          = '0;
      rready          = 1'b0;
      job_start       = 1'b0;
      kernel_complete = '0;
      i_interrupt_ack = 1'b0;
      action_type     = TYPE_ID;
      action_version  = VERSION_ID;
      for (int k = 0; k < KERNEL_NUM; k++)
         exp_cnt[k] = 0;
      repeat (RESET_CYCLES) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
      @(negedge clk);
      test_reset_identity();
      test_control_regs();
      test_dispatch();
      test_completion();
      test_interrupt();
      $display("All tests passed");
      $finish;
   end

   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display("timeout: tests did not finish within %0d clock cycles", WATCHDOG_CYCLES);
      $display("Some tests failed");
      $fatal(1, "watchdog expired");
   end

endmodule

//--- compile.f
global_pkg.sv
axil_reg_port.sv
global_regs.sv
kernel_dispatch.sv
completion_monitor.sv
irq_ctrl.sv
global_slave_top.sv
tb_global_slave.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    := --binary --timing -Wno-fatal
TOP       := tb_global_slave
FILELIST  := compile.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FILELIST))
PASS_MSG  := All tests passed

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
